//--- beatIf.sv
`timescale 1ns/1ps

interface beatIf;
  import portalPkg::*;

  logic             valid;
  logic             ready;
  logic [OFF_W-1:0] offset;
  logic [ID_W-1:0]  id;
  logic             last;
  logic             ctrl;
  logic             ind;

  modport source (
    output valid, offset, id, last, ctrl, ind,
    input  ready
  );

  modport sink (
    input  valid, offset, id, last, ctrl, ind,
    output ready
  );
endinterface

//--- burstSplitter.sv
`timescale 1ns/1ps

module burstSplitter (
  input  logic   CLK,
  input  logic   nRST,
  reqIf.splitter req,
  beatIf.source  beat
);
  import portalPkg::*;

  logic [REQ_W-1:0]  reqIn;
  logic [REQ_W-1:0]  reqEntry;
  logic              reqValid;
  logic [OFF_W-1:0]  reqOff;
  logic [LEN_W-1:0]  reqCnt;
  logic [ID_W-1:0]   reqId;
  logic              reqCtrl;
  logic              reqInd;
  logic              beatSpace;
  logic              stepFire;
  logic              notFirst;
  logic [OFF_W-1:0]  offReg;
  logic [LEN_W-1:0]  cntReg;
  logic              lastReg;
  logic [OFF_W-1:0]  offCur;
  logic [LEN_W-1:0]  cntCur;
  logic              lastCur;
  logic [BEAT_W-1:0] beatOut;

  // A length of 15 gives a count of 0, which still walks 16 beats
  assign reqIn = {req.addr[OFF_W-1:0], req.len + LEN_W'(1), req.id,
                  req.addr[PAGE_HI:PAGE_LO] == '0, req.addr[IND_BIT]};

  fifo1 #(.WIDTH(REQ_W)) reqBuf (
    .CLK(CLK), .nRST(nRST),
    .enqValid(req.valid), .enqReady(req.ready), .enqData(reqIn),
    .deqValid(reqValid), .deqReady(stepFire && lastCur), .deqData(reqEntry)
  );

  assign {reqOff, reqCnt, reqId, reqCtrl, reqInd} = reqEntry;

  // The first beat takes its state from the request, later ones from the walk registers
  assign offCur  = notFirst ? offReg : reqOff;
  assign cntCur  = notFirst ? cntReg : reqCnt;
  assign lastCur = notFirst ? lastReg : (reqCnt == LEN_W'(1));
  assign stepFire = reqValid && beatSpace;

  fifo1 #(.WIDTH(BEAT_W)) beatBuf (
    .CLK(CLK), .nRST(nRST),
    .enqValid(reqValid), .enqReady(beatSpace),
    .enqData({offCur, reqId, lastCur, reqCtrl, reqInd}),
    .deqValid(beat.valid), .deqReady(beat.ready), .deqData(beatOut)
  );

  assign {beat.offset, beat.id, beat.last, beat.ctrl, beat.ind} = beatOut;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      notFirst <= 1'b0;
    end else if (stepFire) begin
      notFirst <= !lastCur;
    end
  end

  // Offsets step by one word and wrap inside the page
  always_ff @(posedge CLK) begin
    if (stepFire) begin
      offReg  <= offCur + OFF_W'(4);
      cntReg  <= cntCur - LEN_W'(1);
      lastReg <= cntCur == LEN_W'(2);
    end
  end

endmodule

//--- fifo1.sv
`timescale 1ns/1ps

module fifo1 #(
  parameter int WIDTH = 8
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enqValid,
  output logic             enqReady,
  input  logic [WIDTH-1:0] enqData,
  output logic             deqValid,
  input  logic             deqReady,
  output logic [WIDTH-1:0] deqData
);

  logic             full;
  logic [WIDTH-1:0] store;

  // Accepts only while empty and offers only while full
  assign enqReady = !full;
  assign deqValid = full;
  assign deqData  = store;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (enqValid && !full) begin
      full <= 1'b1;
    end else if (deqReady && full) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (enqValid && !full) begin
      store <= enqData;
    end
  end

endmodule

//--- portalBridge.sv
`timescale 1ns/1ps

module portalBridge (
  input  logic                         CLK,
  input  logic                         nRST,
  input  logic                         arValid,
  output logic                         arReady,
  input  logic [portalPkg::ADDR_W-1:0] arAddr,
  input  logic [portalPkg::LEN_W-1:0]  arLen,
  input  logic [portalPkg::ID_W-1:0]   arId,
  output logic                         rValid,
  input  logic                         rReady,
  output logic [portalPkg::DATA_W-1:0] rData,
  output logic [portalPkg::ID_W-1:0]   rId,
  output logic                         rLast,
  input  logic                         awValid,
  output logic                         awReady,
  input  logic [portalPkg::ADDR_W-1:0] awAddr,
  input  logic [portalPkg::LEN_W-1:0]  awLen,
  input  logic [portalPkg::ID_W-1:0]   awId,
  input  logic                         wValid,
  output logic                         wReady,
  input  logic [portalPkg::DATA_W-1:0] wData,
  output logic                         bValid,
  input  logic                         bReady,
  output logic [portalPkg::ID_W-1:0]   bId,
  output logic                         interrupt
);

  reqIf  arReq ();
  reqIf  awReq ();
  beatIf rdBeat ();
  beatIf wrBeat ();
  userIf userLink ();

  assign arReq.valid = arValid;
  assign arReq.addr  = arAddr;
  assign arReq.len   = arLen;
  assign arReq.id    = arId;
  assign arReady     = arReq.ready;

  assign awReq.valid = awValid;
  assign awReq.addr  = awAddr;
  assign awReq.len   = awLen;
  assign awReq.id    = awId;
  assign awReady     = awReq.ready;

  burstSplitter readSplit (.CLK(CLK), .nRST(nRST), .req(arReq), .beat(rdBeat));
  burstSplitter writeSplit (.CLK(CLK), .nRST(nRST), .req(awReq), .beat(wrBeat));

  portalDispatch dispatch (
    .CLK(CLK), .nRST(nRST),
    .rdBeat(rdBeat), .wrBeat(wrBeat),
    .wValid(wValid), .wReady(wReady), .wData(wData),
    .rValid(rValid), .rReady(rReady), .rData(rData), .rId(rId), .rLast(rLast),
    .bValid(bValid), .bReady(bReady), .bId(bId),
    .user(userLink), .interrupt(interrupt)
  );

  userEcho echo (.CLK(CLK), .nRST(nRST), .user(userLink));

endmodule

//--- portalBridgeTb.sv
`timescale 1ns/1ps

module portalBridgeTb;
  import portalPkg::*;

  localparam int unsigned SEED = 32'hdfa9;
  localparam int NUM_OPS   = 17;
  localparam int MAX_BEATS = 8;
  localparam int OP_CYCLES = 300;
  localparam bit RD = 1'b0;
  localparam bit WR = 1'b1;

  logic              CLK;
  logic              nRST;
  logic              arValid;
  logic              arReady;
  logic [ADDR_W-1:0] arAddr;
  logic [LEN_W-1:0]  arLen;
  logic [ID_W-1:0]   arId;
  logic              rValid;
  logic              rReady;
  logic [DATA_W-1:0] rData;
  logic [ID_W-1:0]   rId;
  logic              rLast;
  logic              awValid;
  logic              awReady;
  logic [ADDR_W-1:0] awAddr;
  logic [LEN_W-1:0]  awLen;
  logic [ID_W-1:0]   awId;
  logic              wValid;
  logic              wReady;
  logic [DATA_W-1:0] wData;
  logic              bValid;
  logic              bReady;
  logic [ID_W-1:0]   bId;
  logic              interrupt;

  // The words are write data for writes and expected read data for reads
  bit                opWrite [NUM_OPS];
  logic [ADDR_W-1:0] opAddr  [NUM_OPS];
  int                opBeats [NUM_OPS];
  logic [ID_W-1:0]   opId    [NUM_OPS];
  logic              opIrq   [NUM_OPS];
  string             opName  [NUM_OPS];
  logic [DATA_W-1:0] opWords [NUM_OPS][MAX_BEATS];
  int                nOps;

  logic [DATA_W-1:0] gotData [MAX_BEATS];
  logic [ID_W-1:0]   gotId   [MAX_BEATS];
  logic              gotLast [MAX_BEATS];
  int                rCount;
  int                bCount;
  logic [ID_W-1:0]   lastBId;
  int                errors;
  int                passed;
  int                failed;

  tbClock clockGen (.CLK(CLK), .nRST(nRST));

  portalBridge uut (.*);

  task automatic addOp(input bit write, input logic [ADDR_W-1:0] addr, input int beats,
                       input logic [ID_W-1:0] id, input logic irq, input string name);
    opWrite[nOps] = write;
    opAddr[nOps]  = addr;
    opBeats[nOps] = beats;
    opId[nOps]    = id;
    opIrq[nOps]   = irq;
    opName[nOps]  = name;
    nOps++;
  endtask

  task automatic buildTable();
    logic [DATA_W-1:0] r1;
    logic [DATA_W-1:0] r2;
    logic [DATA_W-1:0] r3;
    r1 = $urandom;
    r2 = $urandom;
    r3 = $urandom;
    nOps = 0;
    addOp(RD, 32'h0000, 6, 6'd3, 1'b0, "control page burst");
    opWords[nOps-1] = '{0, 0, 1, 0, 5, 2, 0, 0};
    addOp(RD, 32'h1010, 1, 6'd5, 1'b0, "indication portal id");
    opWords[nOps-1] = '{0: 6, default: 0};
    // Starts at 0x18 and wraps back to offset 0 on the third beat
    addOp(RD, 32'h0018, 8, 6'd7, 1'b0, "offset wrap");
    opWords[nOps-1] = '{0, 0, 0, 0, 1, 0, 5, 2};
    addOp(RD, 32'h0024, 1, 6'd8, 1'b0, "status empty");
    opWords[nOps-1] = '{0: 1, default: 0};
    addOp(WR, 32'h0020, 1, 6'd9, 1'b0, "echo request");
    opWords[nOps-1] = '{0: r1, default: 0};
    addOp(RD, 32'h0024, 1, 6'd10, 1'b0, "status full");
    opWords[nOps-1] = '{default: 0};
    addOp(RD, 32'h1020, 1, 6'd11, 1'b0, "echo indication");
    opWords[nOps-1] = '{0: r1 + 1, default: 0};
    addOp(RD, 32'h1020, 1, 6'd12, 1'b0, "indication empty");
    opWords[nOps-1] = '{default: 0};
    addOp(WR, 32'h0004, 1, 6'd13, 1'b0, "interrupt enable on");
    opWords[nOps-1] = '{0: 1, default: 0};
    addOp(WR, 32'h0020, 1, 6'd14, 1'b1, "interrupt raised");
    opWords[nOps-1] = '{0: r2, default: 0};
    addOp(RD, 32'h1000, 4, 6'd15, 1'b1, "pending flags");
    opWords[nOps-1] = '{1, 0, 1, 1, 0, 0, 0, 0};
    addOp(RD, 32'h1020, 1, 6'd16, 1'b0, "interrupt cleared by read");
    opWords[nOps-1] = '{0: r2 + 1, default: 0};
    addOp(WR, 32'h0020, 1, 6'd17, 1'b1, "interrupt raised again");
    opWords[nOps-1] = '{0: r3, default: 0};
    addOp(WR, 32'h0004, 1, 6'd18, 1'b0, "interrupt enable off");
    opWords[nOps-1] = '{default: 0};
    addOp(RD, 32'h1020, 1, 6'd19, 1'b0, "drain indication");
    opWords[nOps-1] = '{0: r3 + 1, default: 0};
    addOp(WR, 32'h0008, 3, 6'd20, 1'b0, "control page write burst");
    opWords[nOps-1] = '{32'hA, 32'hB, 32'hC, 0, 0, 0, 0, 0};
    addOp(RD, 32'h0024, 1, 6'd21, 1'b0, "status after drain");
    opWords[nOps-1] = '{0: 1, default: 0};
  endtask

  task automatic checkValue(input string name, input logic [DATA_W-1:0] got,
                            input logic [DATA_W-1:0] expected);
    assert (got === expected) else begin
      $display("** Error at %0t: %s is %h, expected %h", $time, name, got, expected);
      errors++;
    end
  endtask

  task automatic finishTest(input string label, input int startErrors);
    if (errors == startErrors) begin
      passed++;
      $display("%s: ok", label);
    end else begin
      failed++;
      $display("%s: failed", label);
    end
  endtask

  task automatic sendAddr(input bit write, input logic [ADDR_W-1:0] addr, input int beats,
                          input logic [ID_W-1:0] id);
    @(negedge CLK);
    if (write) begin
      awValid = 1'b1;
      awAddr  = addr;
      awLen   = LEN_W'(beats - 1);
      awId    = id;
    end else begin
      arValid = 1'b1;
      arAddr  = addr;
      arLen   = LEN_W'(beats - 1);
      arId    = id;
    end
    do @(posedge CLK); while (write ? !awReady : !arReady);
    @(negedge CLK);
    arValid = 1'b0;
    awValid = 1'b0;
  endtask

  task automatic sendWord(input logic [DATA_W-1:0] data);
    @(negedge CLK);
    wValid = 1'b1;
    wData  = data;
    do @(posedge CLK); while (!wReady);
    @(negedge CLK);
    wValid = 1'b0;
  endtask

  task automatic runOp(input int i);
    int startErrors;
    int startB;
    int cycles;
    bit done;
    startErrors = errors;
    startB = bCount;
    rCount = 0;
    sendAddr(opWrite[i], opAddr[i], opBeats[i], opId[i]);
    if (opWrite[i]) begin
      for (int k = 0; k < opBeats[i]; k++) begin
        sendWord(opWords[i][k]);
      end
    end
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < OP_CYCLES) begin
      @(negedge CLK);
      cycles++;
      done = opWrite[i] ? bCount > startB : rCount >= opBeats[i];
    end
    assert (done) else begin
      $display("Test %0d got no complete response within %0d cycles", i, OP_CYCLES);
      errors++;
    end
    // A few idle cycles so that a stray extra response is counted too
    repeat (4) @(negedge CLK);
    if (opWrite[i]) begin
      assert (bCount - startB == 1) else begin
        $display("Test %0d saw %0d write responses instead of one", i, bCount - startB);
        errors++;
      end
      checkValue("bId", lastBId, opId[i]);
    end else begin
      assert (rCount == opBeats[i]) else begin
        $display("Test %0d saw %0d read beats instead of %0d", i, rCount, opBeats[i]);
        errors++;
      end
      for (int k = 0; k < opBeats[i] && k < rCount; k++) begin
        checkValue($sformatf("rData[%0d]", k), gotData[k], opWords[i][k]);
        checkValue($sformatf("rId[%0d]", k), gotId[k], opId[i]);
        checkValue($sformatf("rLast[%0d]", k), gotLast[k], k == opBeats[i] - 1);
      end
    end
    checkValue("interrupt", interrupt, opIrq[i]);
    finishTest($sformatf("Test %0d %s", i, opName[i]), startErrors);
  endtask

  always @(posedge CLK) begin
    if (nRST && rValid && rReady) begin
      if (rCount < MAX_BEATS) begin
        gotData[rCount] = rData;
        gotId[rCount]   = rId;
        gotLast[rCount] = rLast;
      end
      rCount++;
    end
    if (nRST && bValid && bReady) begin
      bCount++;
      lastBId = bId;
    end
  end

  // Random stalls on the response channels
  initial begin
    int rStall;
    int bStall;
    rStall = 0;
    bStall = 0;
    rReady = 1'b0;
    bReady = 1'b0;
    forever begin
      @(negedge CLK);
      if (rStall > 0) begin
        rReady = 1'b0;
        rStall--;
      end else begin
        rReady = 1'b1;
        if ($urandom_range(3) == 0) rStall = $urandom_range(5, 1);
      end
      if (bStall > 0) begin
        bReady = 1'b0;
        bStall--;
      end else begin
        bReady = 1'b1;
        if ($urandom_range(3) == 0) bStall = $urandom_range(5, 1);
      end
    end
  end

  initial begin
    repeat (400 * (NUM_OPS + 1)) @(posedge CLK);
    $display("Watchdog expired before all tests finished");
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    int startErrors;
    void'($urandom(SEED));
    arValid = 1'b0;
    arAddr  = '0;
    arLen   = '0;
    arId    = '0;
    awValid = 1'b0;
    awAddr  = '0;
    awLen   = '0;
    awId    = '0;
    wValid  = 1'b0;
    wData   = '0;
    rCount  = 0;
    bCount  = 0;
    errors  = 0;
    passed  = 0;
    failed  = 0;
    buildTable();
    wait (nRST === 1'b1);
    @(negedge CLK);
    startErrors = errors;
    checkValue("arReady", arReady, 1'b1);
    checkValue("awReady", awReady, 1'b1);
    checkValue("wReady", wReady, 1'b1);
    checkValue("rValid", rValid, 1'b0);
    checkValue("bValid", bValid, 1'b0);
    checkValue("interrupt", interrupt, 1'b0);
    finishTest("Test reset state", startErrors);
    for (int i = 0; i < NUM_OPS; i++) begin
      runOp(i);
    end
    startErrors = errors;
    assert (uut.sva.failCount == 0) else begin
      $display("Bound handshake assertions failed %0d times", uut.sva.failCount);
      errors++;
    end
    finishTest("Test bus handshake rules", startErrors);
    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             passed + failed, passed, failed, errors);
    if (failed == 0 && errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- portalBridge_sva.sv
`timescale 1ns/1ps

module portalBridge_sva (
  input logic                         CLK,
  input logic                         nRST,
  input logic                         arValid,
  input logic                         arReady,
  input logic [portalPkg::ADDR_W-1:0] arAddr,
  input logic [portalPkg::LEN_W-1:0]  arLen,
  input logic [portalPkg::ID_W-1:0]   arId,
  input logic                         awValid,
  input logic                         awReady,
  input logic [portalPkg::ADDR_W-1:0] awAddr,
  input logic [portalPkg::LEN_W-1:0]  awLen,
  input logic [portalPkg::ID_W-1:0]   awId,
  input logic                         wValid,
  input logic                         wReady,
  input logic [portalPkg::DATA_W-1:0] wData,
  input logic                         rValid,
  input logic                         bValid,
  input logic                         bReady,
  input logic                         lastWrite
);

  // Write bursts whose last beat has passed but whose response is still due
  int owed;
  int failCount = 0;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      owed <= 0;
    end else begin
      owed <= owed + int'(lastWrite) - int'(bValid && bReady);
    end
  end

  arHold: assert property (@(posedge CLK) disable iff (!nRST)
    arValid && !arReady |=> arValid && $stable({arAddr, arLen, arId}))
    else begin
      $error("AR request dropped or changed while stalled");
      failCount++;
    end

  awHold: assert property (@(posedge CLK) disable iff (!nRST)
    awValid && !awReady |=> awValid && $stable({awAddr, awLen, awId}))
    else begin
      $error("AW request dropped or changed while stalled");
      failCount++;
    end

  wHold: assert property (@(posedge CLK) disable iff (!nRST)
    wValid && !wReady |=> wValid && $stable(wData))
    else begin
      $error("W word dropped or changed while stalled");
      failCount++;
    end

  rQuietInReset: assert property (@(posedge CLK) !nRST |=> !rValid)
    else begin
      $error("rValid high during reset");
      failCount++;
    end

  bNeedsLastBeat: assert property (@(posedge CLK) disable iff (!nRST)
    bValid |-> owed != 0)
    else begin
      $error("bValid without a finished write burst");
      failCount++;
    end

endmodule

bind portalBridge portalBridge_sva sva (
  .CLK(CLK),
  .nRST(nRST),
  .arValid(arValid),
  .arReady(arReady),
  .arAddr(arAddr),
  .arLen(arLen),
  .arId(arId),
  .awValid(awValid),
  .awReady(awReady),
  .awAddr(awAddr),
  .awLen(awLen),
  .awId(awId),
  .wValid(wValid),
  .wReady(wReady),
  .wData(wData),
  .rValid(rValid),
  .bValid(bValid),
  .bReady(bReady),
  .lastWrite(wrBeat.valid && wrBeat.ready && wrBeat.last)
);

//--- portalDispatch.sv
`timescale 1ns/1ps

module portalDispatch (
  input  logic                     CLK,
  input  logic                     nRST,
  beatIf.sink                      rdBeat,
  beatIf.sink                      wrBeat,
  input  logic                     wValid,
  output logic                     wReady,
  input  logic [portalPkg::DATA_W-1:0] wData,
  output logic                     rValid,
  input  logic                     rReady,
  output logic [portalPkg::DATA_W-1:0] rData,
  output logic [portalPkg::ID_W-1:0]   rId,
  output logic                     rLast,
  output logic                     bValid,
  input  logic                     bReady,
  output logic [portalPkg::ID_W-1:0]   bId,
  userIf.host                      user,
  output logic                     interrupt
);
  import portalPkg::*;

  localparam int RD_W = DATA_W + ID_W + 1;

  logic              intEnable;
  logic              rdSpace;
  logic              rdFire;
  logic [DATA_W-1:0] ctrlValue;
  logic [DATA_W-1:0] dataValue;
  logic [DATA_W-1:0] rdValue;
  logic [RD_W-1:0]   rdOut;
  logic              wdValid;
  logic [DATA_W-1:0] wdData;
  logic              doneSpace;
  logic              wrNeedsUser;
  logic              wrFire;

  // Control page registers are identical on both portals apart from the id word
  always_comb begin
    case (rdBeat.offset)
      5'h00:   ctrlValue = DATA_W'(user.indValid);
      5'h08:   ctrlValue = DATA_W'(1);
      5'h0C:   ctrlValue = DATA_W'(user.indValid);
      OFF_ID:  ctrlValue = rdBeat.ind ? DATA_W'(6) : DATA_W'(5);
      5'h14:   ctrlValue = DATA_W'(2);
      default: ctrlValue = '0;
    endcase
  end

  always_comb begin
    dataValue = '0;
    if (rdBeat.ind) begin
      if (rdBeat.offset == OFF_DATA && user.indValid) begin
        dataValue = user.indData;
      end
    end else if (rdBeat.offset == OFF_STATUS) begin
      dataValue = DATA_W'(user.reqReady);
    end
  end

  assign rdValue = rdBeat.ctrl ? ctrlValue : dataValue;
  assign rdFire = rdBeat.valid && rdSpace;
  assign rdBeat.ready = rdSpace;
  assign user.indPop = rdFire && !rdBeat.ctrl && rdBeat.ind &&
                       rdBeat.offset == OFF_DATA && user.indValid;

  fifo1 #(.WIDTH(RD_W)) readData (
    .CLK(CLK), .nRST(nRST),
    .enqValid(rdBeat.valid), .enqReady(rdSpace),
    .enqData({rdValue, rdBeat.id, rdBeat.last}),
    .deqValid(rValid), .deqReady(rReady), .deqData(rdOut)
  );

  assign {rData, rId, rLast} = rdOut;

  fifo1 #(.WIDTH(DATA_W)) writeData (
    .CLK(CLK), .nRST(nRST),
    .enqValid(wValid), .enqReady(wReady), .enqData(wData),
    .deqValid(wdValid), .deqReady(wrFire), .deqData(wdData)
  );

  // Only the request portal data word goes to the user block
  assign wrNeedsUser = !wrBeat.ctrl && !wrBeat.ind && wrBeat.offset == OFF_DATA;
  assign wrBeat.ready = wdValid && (!wrBeat.last || doneSpace) &&
                        (!wrNeedsUser || user.reqReady);
  assign wrFire = wrBeat.valid && wrBeat.ready;

  assign user.reqValid = wrFire && wrNeedsUser;
  assign user.reqData  = wdData;

  fifo1 #(.WIDTH(ID_W)) writeDone (
    .CLK(CLK), .nRST(nRST),
    .enqValid(wrFire && wrBeat.last), .enqReady(doneSpace), .enqData(wrBeat.id),
    .deqValid(bValid), .deqReady(bReady), .deqData(bId)
  );

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      intEnable <= 1'b0;
    end else if (wrFire && wrBeat.ctrl && wrBeat.offset == OFF_CTRL_IEN) begin
      intEnable <= wdData[0];
    end
  end

  assign interrupt = user.indValid && intEnable;

endmodule

//--- portalPkg.sv
package portalPkg;

  // Bus field widths
  localparam int DATA_W = 32;
  localparam int ADDR_W = 32;
  localparam int ID_W   = 6;
  // Burst length is the beat count minus 1
  localparam int LEN_W  = 4;
  localparam int OFF_W  = 5;

  // Address decode, portal select and page field
  localparam int IND_BIT = 12;
  localparam int PAGE_LO = 5;
  localparam int PAGE_HI = 11;

  // Word offsets with a defined meaning
  localparam logic [OFF_W-1:0] OFF_DATA     = 5'h00;
  localparam logic [OFF_W-1:0] OFF_STATUS   = 5'h04;
  localparam logic [OFF_W-1:0] OFF_CTRL_IEN = 5'h04;
  localparam logic [OFF_W-1:0] OFF_ID       = 5'h10;

  // Request entry fields from the top bit down
  // offset, beat count, id, control page flag, indication flag
  localparam int REQ_W = OFF_W + LEN_W + ID_W + 2;

  // Beat entry fields from the top bit down
  // offset, id, last, control page flag, indication flag
  localparam int BEAT_W = OFF_W + ID_W + 3;

endpackage

//--- reqIf.sv
`timescale 1ns/1ps

interface reqIf;
  import portalPkg::*;

  logic              valid;
  logic              ready;
  logic [ADDR_W-1:0] addr;
  logic [LEN_W-1:0]  len;
  logic [ID_W-1:0]   id;

  modport master (
    output valid, addr, len, id,
    input  ready
  );

  modport splitter (
    input  valid, addr, len, id,
    output ready
  );

endinterface

//--- src.f
portalPkg.sv
reqIf.sv
beatIf.sv
userIf.sv
fifo1.sv
burstSplitter.sv
portalDispatch.sv
userEcho.sv
portalBridge.sv
tbClock.sv
portalBridge_sva.sv
portalBridgeTb.sv

//--- tbClock.sv
`timescale 1ns/1ps

module tbClock #(
  parameter int CLK_PERIOD   = 40,
  parameter int RESET_CYCLES = 16
) (
  output logic CLK,
  output logic nRST
);

  initial begin
    CLK = 1'b0;
    forever #(CLK_PERIOD / 2) CLK = ~CLK;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    nRST = 1'b0;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    nRST = 1'b1;
  end

endmodule

//--- userEcho.sv
`timescale 1ns/1ps

module userEcho (
  input  logic CLK,
  input  logic nRST,
  userIf.user  user
);
  import portalPkg::*;

  logic              full;
  logic [DATA_W-1:0] held;
  logic              accept;

  assign accept = user.reqValid && !full;

  assign user.reqReady = !full;
  assign user.indValid = full;
  assign user.indData  = held;

  // Accept and pop cannot coincide since one needs empty and the other full
  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (accept) begin
      full <= 1'b1;
    end else if (user.indPop) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (accept) begin
      held <= user.reqData + DATA_W'(1);
    end
  end

endmodule

//--- userIf.sv
`timescale 1ns/1ps

interface userIf;
  import portalPkg::*;

  logic              reqValid;
  logic              reqReady;
  logic [DATA_W-1:0] reqData;
  logic              indValid;
  logic [DATA_W-1:0] indData;
  // Single cycle pulse that consumes the pending indication
  logic              indPop;

  modport host (
    output reqValid, reqData, indPop,
    input  reqReady, indValid, indData
  );

  modport user (
    input  reqValid, reqData, indPop,
    output reqReady, indValid, indData
  );
endinterface
